// ==== hw/uart_pkg.sv ====
package uart_pkg;

    // Bit timing, sized for simulation
    localparam int CLKS_PER_BIT = 16;                      // Clock cycles per serial bit
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;        // Offset to mid-bit
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);    // Bit-period counter width

    // 8E1 framing: start, 8 data LSB first, parity, stop
    localparam int DATA_BITS  = 8;                         // Payload bits per frame
    localparam int FRAME_BITS = 11;                        // Bit periods per frame
    localparam int BIT_IDX_W  = $clog2(FRAME_BITS);        // Bit index width, rx and tx

    // Parity seed, 0 gives even parity
    localparam logic PARITY_ODD = 1'b0;

endpackage

// ==== hw/cmd_pkg.sv ====
package cmd_pkg;

    // Command bytes from the host
    typedef enum logic [7:0] {
        OP_ON     = 8'h33,                                 // Set output enable
        OP_OFF    = 8'h66,                                 // Clear output enable
        OP_TOGGLE = 8'h9D                                  // Invert output enable
    } opcode_e;

    // Reply bytes back to the host
    localparam logic [7:0] REPLY_ACK = 8'h3C;              // Recognized command
    localparam logic [7:0] REPLY_NAK = 8'hA5;              // Parity or framing error

    // Power-up wait, sized for simulation
    localparam int STARTUP_CYCLES = 200;                   // Cycles before ready
    localparam int INIT_CNT_W     = $clog2(STARTUP_CYCLES); // Startup counter width

    // Controller states
    typedef enum logic [1:0] {
        ST_INIT,                                           // Power-up wait
        ST_RUN,                                            // Idle, decoding bytes
        ST_SEND                                            // Reply pending on busy tx
    } ctrl_state_e;

endpackage

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rx,            // Serial in, idles high
    output logic [uart_pkg::DATA_BITS-1:0] rx_data,       // Last byte, held to next frame
    output logic                           rx_done,       // Pulse at mid stop bit
    output logic                           rx_parity_err  // Parity mismatch or low stop
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        RX_IDLE,                                           // Waiting for falling edge
        RX_START,                                          // Half bit to confirm start
        RX_DATA,                                           // Eight data bits
        RX_PARITY,                                         // Parity bit
        RX_STOP                                            // Stop bit
    } rx_state_e;

    rx_state_e            state;
    logic                 rx_meta;                         // Synchronizer first stage
    logic                 rx_sync;                         // Synchronized line
    logic                 rx_prev;                         // For edge detect
    logic [BIT_CNT_W-1:0] clk_cnt;                         // Cycles into current bit
    logic [BIT_IDX_W-1:0] bit_idx;                         // Data bit index
    logic [DATA_BITS-1:0] shift_reg;                       // Assembling byte
    logic                 par_acc;                         // Running parity
    logic                 par_bad;                         // Parity bit mismatch
    logic                 half_tick;
    logic                 bit_tick;
    logic                 data_tick;
    logic                 stop_tick;

    assign half_tick = (clk_cnt == BIT_CNT_W'(HALF_BIT - 1));
    assign bit_tick  = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
    assign data_tick = (state == RX_DATA) && bit_tick;     // Mid data bit
    assign stop_tick = (state == RX_STOP) && bit_tick;     // Mid stop bit

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= RX_IDLE;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            par_acc       <= PARITY_ODD;
            par_bad       <= 1'b0;
            rx_done       <= 1'b0;
            rx_parity_err <= 1'b0;
        end else begin
            rx_done <= 1'b0;                               // Default, pulse only
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) begin         // Falling edge, start bit
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        par_acc <= PARITY_ODD;
                        state   <= rx_sync ? RX_IDLE : RX_DATA; // Glitch if high again
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        par_acc <= par_acc ^ rx_sync;      // Parity while shifting
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1)) begin
                            state <= RX_PARITY;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_PARITY: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        par_bad <= par_acc ^ rx_sync;      // Nonzero means mismatch
                        state   <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        rx_done       <= 1'b1;
                        rx_parity_err <= par_bad || !rx_sync; // Low stop is an error too
                        state         <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (data_tick) begin
            shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]}; // LSB arrives first
        end
        if (stop_tick) begin
            rx_data <= shift_reg;                          // Valid with rx_done
        end
    end

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_data,       // Byte to send
    input  logic                           tx_start,      // One-cycle strobe
    output logic                           tx,            // Serial out, idles high
    output logic                           tx_busy        // Frame on the line
);
    import uart_pkg::*;

    logic [BIT_CNT_W-1:0]  clk_cnt;                        // Cycles into current bit
    logic [BIT_IDX_W-1:0]  bit_idx;                        // Bit now on the line
    logic [FRAME_BITS-2:0] frame_sr;                       // Bits after start
    logic                  parity;                         // Parity of tx_data
    logic                  load;                           // Accept a new frame
    logic                  bit_end;                        // Last cycle of a bit

    assign parity  = (^tx_data) ^ PARITY_ODD;
    assign load    = tx_start && !tx_busy;                 // Ignored while busy
    assign bit_end = tx_busy && (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (load) begin
            tx      <= 1'b0;                               // Start bit next cycle
            tx_busy <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1)) begin // Stop bit done
                tx      <= 1'b1;
                tx_busy <= 1'b0;
            end else begin
                tx      <= frame_sr[0];                    // Next bit out
                bit_idx <= bit_idx + 1'b1;
            end
        end else if (tx_busy) begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Frame shifter: data LSB first, parity, stop
    always_ff @(posedge clk) begin
        if (load) begin
            frame_sr <= {1'b1, parity, tx_data};
        end else if (bit_end) begin
            frame_sr <= {1'b1, frame_sr[FRAME_BITS-2:1]};  // Fill with idle level
        end
    end

endmodule

// ==== hw/cmd_ctrl.sv ====
`timescale 1ns/1ns

module cmd_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rx_data,                            // Received byte
    input  logic       rx_done,                            // Byte strobe
    input  logic       rx_parity_err,                      // Bad parity or stop
    input  logic       tx_busy,                            // Transmitter occupied
    output logic [7:0] tx_data,                            // Reply, doubles as pending slot
    output logic       tx_start,                           // Reply strobe
    output logic       ready,                              // Startup wait over
    output logic       out_en,                             // Output enable level
    output logic       err                                 // Error level
);
    import cmd_pkg::*;

    ctrl_state_e           state;
    logic [INIT_CNT_W-1:0] init_cnt;                       // Power-up counter
    opcode_e               rx_op;                          // Byte seen as opcode
    logic [7:0]            reply;                          // Reply for this byte
    logic                  out_en_nxt;
    logic                  err_nxt;
    logic                  accept;                         // Byte to act on
    logic                  tx_free;                        // Safe to strobe tx

    assign rx_op   = opcode_e'(rx_data);
    assign accept  = rx_done && (state != ST_INIT);        // Drop bytes during startup
    assign tx_free = !tx_busy && !tx_start;                // Busy lags strobe by one cycle

    // Command decode and reply choice
    always_comb begin
        reply      = rx_data;                              // Unknown bytes echo back
        out_en_nxt = out_en;
        err_nxt    = err;                                  // Held until a known command
        if (rx_parity_err) begin
            reply   = REPLY_NAK;
            err_nxt = 1'b1;
        end else begin
            case (rx_op)
                OP_ON: begin
                    reply      = REPLY_ACK;
                    out_en_nxt = 1'b1;
                    err_nxt    = 1'b0;
                end
                OP_OFF: begin
                    reply      = REPLY_ACK;
                    out_en_nxt = 1'b0;
                    err_nxt    = 1'b0;
                end
                OP_TOGGLE: begin
                    reply      = REPLY_ACK;
                    out_en_nxt = !out_en;
                    err_nxt    = 1'b0;
                end
                default: begin
                    reply = rx_data;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_INIT;
            init_cnt <= '0;
            ready    <= 1'b0;
            out_en   <= 1'b0;
            err      <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;                              // Strobe, one cycle
            if (accept) begin                              // Command always executes
                out_en <= out_en_nxt;
                err    <= err_nxt;
            end
            case (state)
                ST_INIT: begin
                    if (init_cnt == INIT_CNT_W'(STARTUP_CYCLES - 1)) begin
                        ready <= 1'b1;
                        state <= ST_RUN;
                    end else begin
                        init_cnt <= init_cnt + 1'b1;
                    end
                end
                ST_RUN: begin
                    if (rx_done) begin
                        if (tx_free) begin
                            tx_start <= 1'b1;              // Send right away
                        end else begin
                            state <= ST_SEND;              // Park the reply
                        end
                    end
                end
                ST_SEND: begin
                    // A newer byte overwrites tx_data, sent when tx frees up
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        state    <= ST_RUN;
                    end
                end
                default: state <= ST_INIT;
            endcase
        end
    end

    // Reply register, also the one-deep pending slot
    always_ff @(posedge clk) begin
        if (accept) begin
            tx_data <= reply;                              // Newest byte wins
        end
    end

endmodule

// ==== hw/link_top.sv ====
`timescale 1ns/1ns

module link_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,                                       // Host to board
    output logic tx,                                       // Board to host
    output logic ready,                                    // Green, startup done
    output logic out_en,                                   // Output enable
    output logic err                                       // Red, last byte bad
);

    logic [7:0] rx_data;                                   // Received byte
    logic       rx_done;
    logic       rx_parity_err;
    logic [7:0] tx_data;                                   // Reply byte
    logic       tx_start;
    logic       tx_busy;

    uart_rx u_rx (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx            (rx),
        .rx_data       (rx_data),
        .rx_done       (rx_done),
        .rx_parity_err (rx_parity_err)
    );

    cmd_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_data       (rx_data),
        .rx_done       (rx_done),
        .rx_parity_err (rx_parity_err),
        .tx_busy       (tx_busy),
        .tx_data       (tx_data),
        .tx_start      (tx_start),
        .ready         (ready),
        .out_en        (out_en),
        .err           (err)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== verification/link_tb.sv ====
`timescale 1ns/1ns

module link_tb;
    import uart_pkg::*;
    import cmd_pkg::*;

    localparam int FRAME_CYCLES  = FRAME_BITS * CLKS_PER_BIT;  // One frame on the line
    localparam int SINGLE_FRAMES = 40;                         // Upper bound, one at a time
    localparam int B2B_FRAMES    = 30;                         // Frames with no idle gap
    localparam int TIMEOUT_CYCLES = 16 + 2 * STARTUP_CYCLES
                                  + (3 * SINGLE_FRAMES + 2 * B2B_FRAMES + 8) * FRAME_CYCLES;

    logic clk;
    logic rst_n;
    logic rx;                                                  // Host to DUT
    logic tx;                                                  // DUT to host
    logic ready;
    logic out_en;
    logic err;

    logic [7:0] exp_q[$];                                      // Expected replies, in order
    string      name_q[$];                                     // Test name per reply
    logic [7:0] got_q[$];                                      // Captured replies
    logic       got_par_q[$];                                  // Parity ok per reply
    logic       model_out_en;                                  // Reference state
    logic       model_err;
    int         cycle_cnt;
    int         err_cnt;
    int         check_cnt;
    int         reply_cnt;                                     // Replies seen on tx
    int         checked_cnt;                                   // Replies matched to expects
    int         exp_total;                                     // Replies expected so far

    link_top UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx     (rx),
        .tx     (tx),
        .ready  (ready),
        .out_en (out_en),
        .err    (err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                                 // 8 ns period
    end

    // Reference model: reply and new levels for one received byte
    function automatic logic [9:0] expect_reply(input logic [7:0] data, input logic par_ok,
                                                input logic cur_out_en, input logic cur_err);
        logic [7:0] reply;
        logic       new_out_en;
        logic       new_err;
        reply      = data;                                     // Unknown byte echoes
        new_out_en = cur_out_en;
        new_err    = cur_err;                                  // Held on unknown byte
        if (!par_ok) begin
            reply   = REPLY_NAK;
            new_err = 1'b1;
        end else if (data == OP_ON || data == OP_OFF || data == OP_TOGGLE) begin
            reply   = REPLY_ACK;
            new_err = 1'b0;
            if (data == OP_ON) new_out_en = 1'b1;
            else if (data == OP_OFF) new_out_en = 1'b0;
            else new_out_en = !cur_out_en;
        end
        return {new_err, new_out_en, reply};
    endfunction

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic print_summary();
        $display("Checks: %0d, errors: %0d, replies: %0d", check_cnt, err_cnt, reply_cnt);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;                                                    // Stay 1 ns after the edge
    endtask

    // Serialize one 8E1 frame, called 1 ns after a rising edge
    task automatic send_byte(input logic [7:0] data, input logic bad_par);
        logic [FRAME_BITS-1:0] frame;
        frame = {1'b1, (^data) ^ bad_par, data, 1'b0};         // Stop, parity, data, start
        for (int i = 0; i < FRAME_BITS; i++) begin
            rx = frame[i];
            idle_cycles(CLKS_PER_BIT);
        end
    endtask

    task automatic queue_expect(input string name, input logic [7:0] data,
                                input logic bad_par);
        logic [9:0] res;
        res = expect_reply(data, !bad_par, model_out_en, model_err);
        exp_q.push_back(res[7:0]);
        name_q.push_back(name);
        model_out_en = res[8];
        model_err    = res[9];
        exp_total++;
    endtask

    task automatic wait_replies(input int target, input int max_cycles);
        int waited;
        waited = 0;
        while (checked_cnt < target && waited < max_cycles) begin
            idle_cycles(1);
            waited++;
        end
        if (checked_cnt < target) begin
            $display("Error: reply missing, %0d of %0d replies arrived", checked_cnt, target);
            err_cnt++;
        end
    endtask

    // One command, its reply and the levels after it
    task automatic run_cmd(input string name, input logic [7:0] data, input logic bad_par);
        queue_expect(name, data, bad_par);
        send_byte(data, bad_par);
        wait_replies(exp_total, 3 * FRAME_CYCLES);
        check_val({name, " out_en"}, 32'(model_out_en), 32'(out_en));
        check_val({name, " err"}, 32'(model_err), 32'(err));
    endtask

    // Reply capture, sampled on falling clock edges away from tx updates
    initial begin : tx_monitor
        logic [7:0] data;
        logic       par_bit;
        logic       stop_bit;
        forever begin
            @(negedge tx);
            repeat (HALF_BIT) @(negedge clk);                  // Middle of start bit
            if (tx !== 1'b0) begin
                $display("Error: start bit on tx did not last half a bit");
                err_cnt++;
            end else begin
                for (int i = 0; i < DATA_BITS; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[i] = tx;                              // LSB first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                par_bit = tx;
                repeat (CLKS_PER_BIT) @(negedge clk);
                stop_bit = tx;
                if (stop_bit !== 1'b1) begin
                    $display("Error: stop bit on tx was low, reply %0h", data);
                    err_cnt++;
                end
                got_q.push_back(data);
                got_par_q.push_back(par_bit == ^data);         // Even parity
                reply_cnt++;
            end
        end
    end

    // Compare each captured reply against the next expected one
    initial begin : reply_compare
        logic [7:0] got_byte;
        logic [7:0] exp_byte;
        logic       par_ok;
        string      name;
        forever begin
            @(posedge clk);
            while (got_q.size() > 0) begin
                got_byte = got_q.pop_front();
                par_ok   = got_par_q.pop_front();
                if (exp_q.size() == 0) begin
                    $display("Error: unexpected reply %0h on tx", got_byte);
                    err_cnt++;
                end else begin
                    exp_byte = exp_q.pop_front();
                    name     = name_q.pop_front();
                    check_val(name, 32'(exp_byte), 32'(got_byte));
                    check_val({name, " parity"}, 32'd1, 32'(par_ok));
                    checked_cnt++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_summary();
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin : stimulus
        logic [7:0] b;
        logic       bad;
        int         kind;
        int         release_cycle;
        int         waited;
        rst_n        = 1'b0;
        rx           = 1'b1;                                   // Line idles high
        model_out_en = 1'b0;
        model_err    = 1'b0;
        cycle_cnt    = 0;
        err_cnt      = 0;
        check_cnt    = 0;
        reply_cnt    = 0;
        checked_cnt  = 0;
        exp_total    = 0;
        void'($urandom(37));                                   // Seed once
        idle_cycles(16);
        rst_n = 1'b1;
        release_cycle = cycle_cnt;

        // After reset, then a byte during the power-up wait
        check_val("reset tx", 32'd1, 32'(tx));
        check_val("reset ready", 32'd0, 32'(ready));
        check_val("reset out_en", 32'd0, 32'(out_en));
        check_val("reset err", 32'd0, 32'(err));
        send_byte(OP_ON, 1'b0);                                // Must be dropped
        check_val("ready low during wait", 32'd0, 32'(ready));
        waited = 0;
        while (!ready && waited < 2 * STARTUP_CYCLES) begin
            idle_cycles(1);
            waited++;
        end
        check_val("ready delay", 32'(STARTUP_CYCLES), 32'(cycle_cnt - release_cycle));
        idle_cycles(2 * FRAME_CYCLES);
        check_val("no reply before ready", 32'd0, 32'(reply_cnt));
        check_val("early byte out_en", 32'd0, 32'(out_en));

        run_cmd("on", OP_ON, 1'b0);
        run_cmd("off", OP_OFF, 1'b0);
        run_cmd("on again", OP_ON, 1'b0);
        run_cmd("off again", OP_OFF, 1'b0);

        for (int i = 0; i < 6; i++) begin
            run_cmd($sformatf("toggle %0d", i), OP_TOGGLE, 1'b0);
        end

        run_cmd("parity on", OP_ON, 1'b1);                     // NAK, out_en kept
        run_cmd("unknown after nak", 8'h00, 1'b0);             // err stays high
        run_cmd("parity random", 8'($urandom), 1'b1);
        run_cmd("err clear", OP_TOGGLE, 1'b0);

        for (int i = 0; i < 20; i++) begin
            do begin
                b = 8'($urandom);
            end while (b == OP_ON || b == OP_OFF || b == OP_TOGGLE);
            run_cmd($sformatf("unknown %0d", i), b, 1'b0);
        end

        // Back-to-back frames, replies checked in order
        for (int i = 0; i < B2B_FRAMES; i++) begin
            kind = int'($urandom % 4);
            case (kind)
                0:       b = OP_ON;
                1:       b = OP_OFF;
                2:       b = OP_TOGGLE;
                default: b = 8'($urandom);
            endcase
            bad = ($urandom % 6 == 0);                         // Some bad parity
            queue_expect($sformatf("b2b frame %0d", i), b, bad);
            send_byte(b, bad);
        end
        wait_replies(exp_total, 4 * FRAME_CYCLES);
        idle_cycles(2 * FRAME_CYCLES);                         // Catch any extra reply
        check_val("b2b reply count", 32'(exp_total), 32'(reply_cnt));
        check_val("b2b leftover expects", 32'd0, 32'(exp_q.size()));
        check_val("b2b out_en", 32'(model_out_en), 32'(out_en));
        check_val("b2b err", 32'(model_err), 32'(err));

        print_summary();
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/uart_pkg.sv
hw/cmd_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_ctrl.sv
hw/link_top.sv
verification/link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the UART command link testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=link_tb
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f compile.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
